// File: design/bpu_pkg.sv
package bpu_pkg;

    ////////////////////////////////////////////////////////////
    // basic widths

    typedef logic [31:0] bus32_t;

    localparam int N_SLOTS = 2;

    // index sits right above the word offset
    localparam int INDEX_BITS = 6;
    localparam int N_ENTRIES  = 1 << INDEX_BITS;
    localparam int INDEX_LSB  = 2;
    localparam int TAG_BITS   = 24;
    localparam int TAG_LSB    = INDEX_LSB + INDEX_BITS;

    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0]   tag_t;

    ////////////////////////////////////////////////////////////
    // direction counters and target entries

    // top bit set means predict taken
    typedef logic [1:0] counter_t;

    localparam counter_t CNT_RESET = 2'b01;
    localparam counter_t CNT_MAX   = 2'b11;
    localparam counter_t CNT_MIN   = 2'b00;

    typedef struct packed {
        logic   valid;
        tag_t   tag;
        bus32_t target;
    } btb_entry_t;

    // inclusive opcode range of the branch group
    localparam logic [5:0] BR_OP_LO = 6'b010010;
    localparam logic [5:0] BR_OP_HI = 6'b011011;

    // update handshake states
    typedef enum logic [1:0] {
        UPD_IDLE,
        UPD_WRITE,
        UPD_HOLD
    } upd_state_t;

    function automatic index_t pc_index(input bus32_t pc);
        return pc[INDEX_LSB +: INDEX_BITS];
    endfunction

    function automatic tag_t pc_tag(input bus32_t pc);
        return pc[TAG_LSB +: TAG_BITS];
    endfunction

endpackage

// File: design/branch_update_if.sv
`timescale 1ns/100ps

interface branch_update_if;
    import bpu_pkg::*;

    logic       wr_en;
    bus32_t     wr_pc;
    counter_t   wr_cnt;
    btb_entry_t wr_btb;

    // read port used by the updater to fetch the old counter
    bus32_t     rd_pc;
    counter_t   rd_cnt;

    modport updater (output wr_en, wr_pc, wr_cnt, wr_btb, rd_pc, input rd_cnt);

    modport tbl (input wr_en, wr_pc, wr_cnt, wr_btb, rd_pc, output rd_cnt);

endinterface

// File: design/fetch_slot_if.sv
`timescale 1ns/100ps

interface fetch_slot_if;
    import bpu_pkg::*;

    // one entry per instruction of the fetch group
    bus32_t [N_SLOTS-1:0] slot_pc;
    logic   [N_SLOTS-1:0] is_branch;
    logic   [N_SLOTS-1:0] slot_en;

    modport producer (output slot_pc, is_branch, slot_en);

    modport consumer (input slot_pc, is_branch, slot_en);

endinterface

// File: design/branch_predecode.sv
`timescale 1ns/100ps

module branch_predecode (
    input  bpu_pkg::bus32_t                         fetch_pc,
    input  bpu_pkg::bus32_t [bpu_pkg::N_SLOTS-1:0]  inst,
    input  logic            [bpu_pkg::N_SLOTS-1:0]  inst_en,
    input  logic                                    stall,
    fetch_slot_if.producer                          slots
);
    import bpu_pkg::*;

    bus32_t [N_SLOTS-1:0] inst_m;
    logic   [5:0]         opcode [N_SLOTS];

    ////////////////////////////////////////////////////////////
    // stall masking

    // a stalled group looks like all-zero words, never a branch
    always_comb begin
        for (int i = 0; i < N_SLOTS; i++) begin
            inst_m[i] = stall ? '0 : inst[i];
            opcode[i] = inst_m[i][31:26];
        end
    end

    ////////////////////////////////////////////////////////////
    // slot addresses and branch classification

    always_comb begin
        for (int i = 0; i < N_SLOTS; i++) begin
            // consecutive words in the group
            slots.slot_pc[i]   = fetch_pc + bus32_t'(4 * i);
            slots.is_branch[i] = (opcode[i] >= BR_OP_LO) && (opcode[i] <= BR_OP_HI);
            slots.slot_en[i]   = inst_en[i] && !stall;
        end
    end

endmodule

// File: design/pred_table.sv
`timescale 1ns/100ps

module pred_table #(
    parameter type    entry_t   = bpu_pkg::counter_t,
    parameter entry_t RESET_VAL = '0
) (
    input  logic                                clk,
    input  logic                                arst_n,
    fetch_slot_if.consumer                      slots,
    branch_update_if.tbl                        upd,
    output entry_t      [bpu_pkg::N_SLOTS-1:0]  rd_entry,
    output logic        [bpu_pkg::N_SLOTS-1:0]  rd_tag_hit
);
    import bpu_pkg::*;

    // payload shape picks which write field of the update bus applies
    localparam bit IS_BTB = ($bits(entry_t) == $bits(btb_entry_t));

    entry_t                   mem [N_ENTRIES];
    entry_t                   wr_data;
    btb_entry_t [N_SLOTS-1:0] slot_view;

    assign wr_data = IS_BTB ? entry_t'(upd.wr_btb) : entry_t'(upd.wr_cnt);

    ////////////////////////////////////////////////////////////
    // storage

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < N_ENTRIES; i++) begin
                mem[i] <= RESET_VAL;
            end
        end else if (upd.wr_en) begin
            mem[pc_index(upd.wr_pc)] <= wr_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // lookup ports

    always_comb begin
        for (int i = 0; i < N_SLOTS; i++) begin
            rd_entry[i]   = mem[pc_index(slots.slot_pc[i])];
            // tag compare only means something on the target table
            slot_view[i]  = btb_entry_t'(rd_entry[i]);
            rd_tag_hit[i] = (slot_view[i].tag == pc_tag(slots.slot_pc[i]));
        end
    end

    // old counter for the read-modify-write in the updater
    assign upd.rd_cnt = counter_t'(mem[pc_index(upd.rd_pc)]);

endmodule

// File: design/predictor_update.sv
`timescale 1ns/100ps

module predictor_update (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    update_req,
    output logic                    update_ack,
    input  bpu_pkg::bus32_t         upd_pc,
    input  logic                    upd_taken,
    input  bpu_pkg::bus32_t         upd_target,
    branch_update_if.updater        bht_port,
    branch_update_if.updater        btb_port
);
    import bpu_pkg::*;

    upd_state_t state_q;
    upd_state_t state_d;

    bus32_t     pc_q;
    bus32_t     target_q;
    logic       taken_q;

    counter_t   cnt_old;
    counter_t   cnt_new;
    btb_entry_t btb_new;
    logic       write_phase;

    ////////////////////////////////////////////////////////////
    // handshake FSM

    always_comb begin
        state_d = state_q;
        case (state_q)
            UPD_IDLE: begin
                if (update_req) begin
                    state_d = UPD_WRITE;
                end
            end
            // tables written at the edge leaving this state
            UPD_WRITE: begin
                state_d = UPD_HOLD;
            end
            UPD_HOLD: begin
                if (!update_req) begin
                    state_d = UPD_IDLE;
                end
            end
            default: begin
                state_d = UPD_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= UPD_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign update_ack  = (state_q == UPD_HOLD);
    assign write_phase = (state_q == UPD_WRITE);

    // capture the resolved branch when a request is accepted
    always_ff @(posedge clk) begin
        if (state_q == UPD_IDLE && update_req) begin
            pc_q     <= upd_pc;
            taken_q  <= upd_taken;
            target_q <= upd_target;
        end
    end

    ////////////////////////////////////////////////////////////
    // new table contents

    assign cnt_old = bht_port.rd_cnt;

    // saturating step toward the outcome
    always_comb begin
        if (taken_q) begin
            cnt_new = (cnt_old == CNT_MAX) ? CNT_MAX : cnt_old + 2'd1;
        end else begin
            cnt_new = (cnt_old == CNT_MIN) ? CNT_MIN : cnt_old - 2'd1;
        end
    end

    assign btb_new = '{valid: 1'b1, tag: pc_tag(pc_q), target: target_q};

    assign bht_port.wr_en  = write_phase;
    assign bht_port.wr_pc  = pc_q;
    assign bht_port.wr_cnt = cnt_new;
    assign bht_port.wr_btb = btb_new;
    assign bht_port.rd_pc  = pc_q;

    // not-taken outcomes leave the target entry alone
    assign btb_port.wr_en  = write_phase && taken_q;
    assign btb_port.wr_pc  = pc_q;
    assign btb_port.wr_cnt = cnt_new;
    assign btb_port.wr_btb = btb_new;
    assign btb_port.rd_pc  = pc_q;

endmodule

// File: design/pred_select.sv
`timescale 1ns/100ps

module pred_select (
    fetch_slot_if.consumer                          slots,
    input  bpu_pkg::counter_t   [bpu_pkg::N_SLOTS-1:0] cnt,
    input  bpu_pkg::btb_entry_t [bpu_pkg::N_SLOTS-1:0] btb,
    input  logic                [bpu_pkg::N_SLOTS-1:0] btb_hit,
    output logic                [bpu_pkg::N_SLOTS-1:0] pred_taken,
    output bpu_pkg::bus32_t                            pred_target,
    output logic                                       taken_sure,
    output logic                [bpu_pkg::N_SLOTS-1:0] fetch_inst_en
);
    import bpu_pkg::*;

    logic [N_SLOTS-1:0] slot_taken;

    // direction per slot, then the full redirect condition
    always_comb begin
        for (int i = 0; i < N_SLOTS; i++) begin
            pred_taken[i] = slots.is_branch[i] && cnt[i][1];
            slot_taken[i] = pred_taken[i] && slots.slot_en[i]
                            && btb[i].valid && btb_hit[i];
        end
    end

    ////////////////////////////////////////////////////////////
    // first taken slot wins

    always_comb begin
        fetch_inst_en[0] = 1'b1;
        fetch_inst_en[1] = 1'b1;
        pred_target      = '0;
        taken_sure       = 1'b0;
        if (slot_taken[0]) begin
            // second word lies past the redirect
            fetch_inst_en[1] = 1'b0;
            pred_target      = btb[0].target;
            taken_sure       = 1'b1;
        end else if (slot_taken[1]) begin
            pred_target      = btb[1].target;
            taken_sure       = 1'b1;
        end
    end

endmodule

// File: design/branch_predict_top.sv
`timescale 1ns/100ps

module branch_predict_top (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  bpu_pkg::bus32_t                        fetch_pc,
    input  bpu_pkg::bus32_t [bpu_pkg::N_SLOTS-1:0] inst,
    input  logic            [bpu_pkg::N_SLOTS-1:0] inst_en,
    input  logic                                   stall,
    input  logic                                   update_req,
    output logic                                   update_ack,
    input  bpu_pkg::bus32_t                        upd_pc,
    input  logic                                   upd_taken,
    input  bpu_pkg::bus32_t                        upd_target,
    output logic            [bpu_pkg::N_SLOTS-1:0] is_branch,
    output logic            [bpu_pkg::N_SLOTS-1:0] pred_taken,
    output bpu_pkg::bus32_t                        pred_target,
    output logic                                   taken_sure,
    output logic            [bpu_pkg::N_SLOTS-1:0] fetch_inst_en
);
    import bpu_pkg::*;

    fetch_slot_if    slots ();
    branch_update_if bht_upd ();
    branch_update_if btb_upd ();

    counter_t   [N_SLOTS-1:0] bht_cnt;
    btb_entry_t [N_SLOTS-1:0] btb_entry;
    logic       [N_SLOTS-1:0] btb_hit;

    assign is_branch = slots.is_branch;

    ////////////////////////////////////////////////////////////
    // lookup path

    branch_predecode u_predecode (
        .fetch_pc (fetch_pc),
        .inst     (inst),
        .inst_en  (inst_en),
        .stall    (stall),
        .slots    (slots)
    );

    pred_table #(
        .entry_t   (counter_t),
        .RESET_VAL (CNT_RESET)
    ) u_bht (
        .clk        (clk),
        .arst_n     (arst_n),
        .slots      (slots),
        .upd        (bht_upd),
        .rd_entry   (bht_cnt),
        .rd_tag_hit ()
    );

    // entries reset invalid
    pred_table #(
        .entry_t   (btb_entry_t),
        .RESET_VAL ('0)
    ) u_btb (
        .clk        (clk),
        .arst_n     (arst_n),
        .slots      (slots),
        .upd        (btb_upd),
        .rd_entry   (btb_entry),
        .rd_tag_hit (btb_hit)
    );

    pred_select u_select (
        .slots         (slots),
        .cnt           (bht_cnt),
        .btb           (btb_entry),
        .btb_hit       (btb_hit),
        .pred_taken    (pred_taken),
        .pred_target   (pred_target),
        .taken_sure    (taken_sure),
        .fetch_inst_en (fetch_inst_en)
    );

    ////////////////////////////////////////////////////////////
    // training path

    predictor_update u_update (
        .clk        (clk),
        .arst_n     (arst_n),
        .update_req (update_req),
        .update_ack (update_ack),
        .upd_pc     (upd_pc),
        .upd_taken  (upd_taken),
        .upd_target (upd_target),
        .bht_port   (bht_upd),
        .btb_port   (btb_upd)
    );

endmodule

// File: verification/branch_predict_tb.sv
`timescale 1ns/100ps

module branch_predict_tb;
    import bpu_pkg::*;

    localparam int     N_TESTS = 6;
    localparam bus32_t BR_INST = 32'h4c00_0010;
    localparam bus32_t PC_A    = 32'h0000_1040;
    localparam bus32_t PC_B    = 32'h0000_2080;
    localparam bus32_t PC_C    = 32'h0000_3010;

    logic                 clk;
    logic                 arst_n;
    bus32_t               fetch_pc;
    bus32_t [N_SLOTS-1:0] inst;
    logic   [N_SLOTS-1:0] inst_en;
    logic                 stall;
    logic                 update_req;
    logic                 update_ack;
    bus32_t               upd_pc;
    logic                 upd_taken;
    bus32_t               upd_target;
    logic   [N_SLOTS-1:0] is_branch;
    logic   [N_SLOTS-1:0] pred_taken;
    bus32_t               pred_target;
    logic                 taken_sure;
    logic   [N_SLOTS-1:0] fetch_inst_en;

    // reference copy of both tables
    logic [1:0]  m_cnt   [64];
    logic        m_valid [64];
    logic [23:0] m_tag   [64];
    bus32_t      m_tgt   [64];

    int errors;
    int tests_run;
    int tests_failed;

    branch_predict_top branch_predict_top_i (.*);

    always #4 clk = ~clk;

    // watchdog sized from the test count
    initial begin
        #(N_TESTS * 2000);
        $display("timeout: run did not finish within %0d ns", N_TESTS * 2000);
        $display("=== FAIL ===");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // helpers

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    task automatic model_update(input bus32_t pc, input logic tk, input bus32_t tgt);
        logic [5:0] idx;
        idx = pc[7:2];
        if (tk) begin
            m_cnt[idx]   = (m_cnt[idx] == 2'b11) ? 2'b11 : m_cnt[idx] + 2'b01;
            m_valid[idx] = 1'b1;
            m_tag[idx]   = pc[31:8];
            m_tgt[idx]   = tgt;
        end else begin
            m_cnt[idx] = (m_cnt[idx] == 2'b00) ? 2'b00 : m_cnt[idx] - 2'b01;
        end
    endtask

    // drive one fetch group and compare every lookup output
    task automatic check_lookup(input bus32_t pc, input bus32_t i0, input bus32_t i1,
                                input logic [1:0] en, input logic st);
        bus32_t     spc;
        bus32_t     w;
        logic [5:0] op;
        logic [5:0] idx;
        logic [1:0] e_br;
        logic [1:0] e_pt;
        logic [1:0] e_tk;
        bus32_t     tg [2];
        bus32_t     e_tgt;
        @(posedge clk);
        #1;
        fetch_pc = pc;
        inst[0]  = i0;
        inst[1]  = i1;
        inst_en  = en;
        stall    = st;
        #2;
        for (int s = 0; s < 2; s++) begin
            w       = st ? 32'h0 : ((s == 0) ? i0 : i1);
            op      = w[31:26];
            spc     = pc + 32'(4 * s);
            idx     = spc[7:2];
            e_br[s] = (op >= BR_OP_LO) && (op <= BR_OP_HI);
            e_pt[s] = e_br[s] && m_cnt[idx][1];
            e_tk[s] = e_pt[s] && en[s] && !st && m_valid[idx] && (m_tag[idx] == spc[31:8]);
            tg[s]   = m_tgt[idx];
        end
        e_tgt = e_tk[0] ? tg[0] : (e_tk[1] ? tg[1] : 32'h0);
        check_val("is_branch", is_branch, e_br);
        check_val("pred_taken", pred_taken, e_pt);
        check_val("pred_target", pred_target, e_tgt);
        check_val("taken_sure", taken_sure, e_tk[0] | e_tk[1]);
        check_val("fetch_inst_en", fetch_inst_en, e_tk[0] ? 2'b01 : 2'b11);
    endtask

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (update_ack !== level && n < 20);
        assert (update_ack === level) else begin
            $display("update_ack did not reach %b within %0d cycles", level, n);
            errors++;
        end
    endtask

    // one full four-phase transaction
    task automatic do_update(input bus32_t pc, input logic tk, input bus32_t tgt);
        @(posedge clk);
        #1;
        upd_pc     = pc;
        upd_taken  = tk;
        upd_target = tgt;
        update_req = 1'b1;
        wait_ack(1'b1);
        update_req = 1'b0;
        wait_ack(1'b0);
        model_update(pc, tk, tgt);
    endtask

    function automatic bus32_t rand_inst();
        logic [5:0] op;
        op = ($urandom % 4 == 0) ? 6'($urandom) : BR_OP_LO + 6'($urandom % 10);
        return {op, 26'($urandom)};
    endfunction

    function automatic bus32_t rand_pc();
        logic [23:0] tag;
        tag = ($urandom % 2 == 0) ? 24'h000100 : 24'h000200;
        return {tag, 3'b000, 3'($urandom), 2'b00};
    endfunction

    ////////////////////////////////////////////////////////////
    // directed tests

    task automatic test_reset_state();
        int e0;
        e0 = errors;
        for (int i = 0; i < 20; i++) begin
            check_lookup($urandom, rand_inst(), rand_inst(), 2'b11, 1'b0);
            check_val("taken_sure", taken_sure, 1'b0);
        end
        finish_test("reset state", e0);
    endtask

    task automatic test_handshake();
        int e0;
        e0 = errors;
        @(posedge clk);
        #1;
        upd_pc     = PC_C;
        upd_taken  = 1'b1;
        upd_target = 32'h0000_8800;
        update_req = 1'b1;
        @(posedge clk);
        #1;
        check_val("update_ack", update_ack, 1'b0);
        @(posedge clk);
        #1;
        check_val("update_ack", update_ack, 1'b1);
        // ack must hold while the source holds req
        repeat (5) begin
            @(posedge clk);
            #1;
            check_val("update_ack", update_ack, 1'b1);
        end
        update_req = 1'b0;
        @(posedge clk);
        #1;
        check_val("update_ack", update_ack, 1'b0);
        model_update(PC_C, 1'b1, 32'h0000_8800);
        check_lookup(PC_C, BR_INST, 32'h0, 2'b11, 1'b0);
        // a second write during the hold would leave this one taken
        do_update(PC_C, 1'b0, 32'h0);
        check_lookup(PC_C, BR_INST, 32'h0, 2'b11, 1'b0);
        finish_test("four-phase handshake", e0);
    endtask

    task automatic test_training();
        int e0;
        e0 = errors;
        check_lookup(PC_A, BR_INST, 32'h0, 2'b11, 1'b0);
        do_update(PC_A, 1'b1, 32'h0000_4000);
        check_lookup(PC_A, BR_INST, 32'h0, 2'b11, 1'b0);
        check_val("pred_taken", pred_taken, 2'b01);
        do_update(PC_A, 1'b0, 32'h0);
        check_lookup(PC_A, BR_INST, 32'h0, 2'b11, 1'b0);
        check_val("pred_taken", pred_taken, 2'b00);
        repeat (4) do_update(PC_A, 1'b1, 32'h0000_4400);
        do_update(PC_A, 1'b0, 32'h0);
        check_lookup(PC_A, BR_INST, 32'h0, 2'b11, 1'b0);
        check_val("taken_sure", taken_sure, 1'b1);
        finish_test("training", e0);
    endtask

    task automatic test_priority();
        int e0;
        e0 = errors;
        do_update(PC_B, 1'b1, 32'h0000_5000);
        do_update(PC_B + 32'd4, 1'b1, 32'h0000_6000);
        check_lookup(PC_B, BR_INST, BR_INST, 2'b11, 1'b0);
        check_val("pred_target", pred_target, 32'h0000_5000);
        check_val("fetch_inst_en", fetch_inst_en, 2'b01);
        do_update(PC_B, 1'b0, 32'h0);
        check_lookup(PC_B, BR_INST, BR_INST, 2'b11, 1'b0);
        check_val("pred_target", pred_target, 32'h0000_6000);
        check_val("fetch_inst_en", fetch_inst_en, 2'b11);
        finish_test("slot priority", e0);
    endtask

    task automatic test_masking();
        int e0;
        e0 = errors;
        check_lookup(PC_A, BR_INST, 32'h0, 2'b11, 1'b1);
        check_val("taken_sure", taken_sure, 1'b0);
        check_lookup(PC_A, BR_INST, 32'h0, 2'b10, 1'b0);
        check_val("taken_sure", taken_sure, 1'b0);
        // same index with another tag
        check_lookup(PC_A ^ 32'h0001_0000, BR_INST, 32'h0, 2'b11, 1'b0);
        check_val("taken_sure", taken_sure, 1'b0);
        finish_test("masking", e0);
    endtask

    task automatic test_random_mix();
        int e0;
        e0 = errors;
        for (int i = 0; i < 200; i++) begin
            if (i % 8 == 0) begin
                do_update(rand_pc(), 1'($urandom), $urandom & 32'hffff_fffc);
            end
            check_lookup(rand_pc(), rand_inst(), rand_inst(), 2'($urandom),
                         ($urandom % 8) == 0);
        end
        finish_test("random mix", e0);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        void'($urandom(32'h5510132f));
        clk        = 1'b0;
        arst_n     = 1'b0;
        fetch_pc   = '0;
        inst       = '0;
        inst_en    = '0;
        stall      = 1'b0;
        update_req = 1'b0;
        upd_pc     = '0;
        upd_taken  = 1'b0;
        upd_target = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < 64; i++) begin
            m_cnt[i]   = 2'b01;
            m_valid[i] = 1'b0;
            m_tag[i]   = '0;
            m_tgt[i]   = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;

        test_reset_state();
        test_handshake();
        test_training();
        test_priority();
        test_masking();
        test_random_mix();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: vlog.f
design/bpu_pkg.sv
design/branch_update_if.sv
design/fetch_slot_if.sv
design/branch_predecode.sv
design/pred_table.sv
design/predictor_update.sv
design/pred_select.sv
design/branch_predict_top.sv
verification/branch_predict_tb.sv

// File: Bender.yml
package:
  name: branch_predict

sources:
  - files:
      - design/bpu_pkg.sv
      - design/branch_update_if.sv
      - design/fetch_slot_if.sv
      - design/branch_predecode.sv
      - design/pred_table.sv
      - design/predictor_update.sv
      - design/pred_select.sv
      - design/branch_predict_top.sv
  - target: test
    files:
      - verification/branch_predict_tb.sv
